// File: s16b_golden.txt
# op addr(byte address, hex) dsn(UDS bit 1, LDS bit 0, active low) wdata expected_rdata
# W rows ignore the last column, R rows compare rdata with it
R 000000 0 0000 ffff
W 000000 0 1234 0000
R 000000 0 0000 ffff
R 400000 0 0000 ffff
W 40000c 2 aa06 0000
W 40000e 2 0020 0000
W 400012 2 0030 0000
W 400012 1 0050 0000
W 400016 0 0031 0000
W 40001a 2 ff32 0000
R 400012 0 0000 ffff
W 200100 0 1234 0000
R 200100 0 0000 1234
W 200100 2 ffab 0000
R 200100 0 0000 12ab
W 200100 1 cdff 0000
R 200100 0 0000 cdab
W 200100 3 0000 0000
R 200100 0 0000 cdab
R 204100 0 0000 cdab
R 27c100 0 0000 cdab
W 258202 0 5a5a 0000
R 200202 0 0000 5a5a
R 280100 0 0000 ffff
W 300040 0 1111 0000
W 310040 0 2222 0000
W 320040 0 3333 0000
R 300040 0 0000 1111
R 310040 0 0000 2222
R 320040 0 0000 3333
R 301040 0 0000 1111
W 320040 2 00cc 0000
R 320040 0 0000 33cc
R 500040 0 0000 ffff

// File: flist.f
s16b_bus_pkg.sv
s16b_map_pkg.sv
s16b_mem_map.sv
s16b_bus_ctrl.sv
s16b_work_ram.sv
s16b_video_ram.sv
s16b_top.sv
tb_s16b_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_s16b_top -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_s16b_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q 'All tests passed!'; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: tb_s16b_top.sv
// Testbench for the memory mapper top level, replays the golden transaction list over req/ack
`timescale 1ns/1ps

module tb_s16b_top;

    localparam int ACK_EDGES  = 4;  // Edge that samples req, then three more
    localparam int DROP_EDGES = 1;  // ack falls on the first req-low edge
    localparam int WAIT_LIMIT = 32; // Cycles before a handshake wait gives up

    logic        clk;
    logic        rst;
    logic        req;
    logic        we;
    logic [23:1] addr;  // Word address, A0 not on the bus
    logic [1:0]  dsn;   // UDS on bit 1, LDS on bit 0, active low
    logic [15:0] wdata;
    logic        ack;
    logic [15:0] rdata;

    int          mismatches;
    int          timeouts;
    int          file_errors;
    int          num_txn;
    int          line_no;   // Golden file line being replayed
    logic        aborted;   // Handshake lost, stop replaying
    logic [31:0] lfsr;

    s16b_top #(.WRAM_AW(13), .VRAM_AW(11)) uut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .dsn   (dsn),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    always #4 clk = ~clk; // 8 ns period

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (golden line %0d)",
                     name, got, exp, line_no);
        end
    endtask

    // Counts falling edges until ack reaches level
    task automatic wait_ack(input logic level, output int edges);
        edges = 0;
        while (ack !== level && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        if (ack !== level) begin
            timeouts++;
            aborted = 1'b1;
            $display("Timeout: ack never went to %0d within %0d cycles (golden line %0d)",
                     level, WAIT_LIMIT, line_no);
        end
    endtask

    // One four-phase transfer, entered and left on a falling edge
    task automatic bus_transfer(input logic is_write, input logic [23:0] byte_addr,
                                input logic [1:0] strb, input logic [15:0] data,
                                input logic [15:0] expected);
        int edges;
        req   = 1'b1;
        we    = is_write;
        addr  = byte_addr[23:1];
        dsn   = strb;
        wdata = data;
        wait_ack(1'b1, edges);
        if (!aborted) begin
            check_value("ack rise edges", 32'(edges), 32'(ACK_EDGES));
            if (!is_write) begin
                check_value("rdata", {16'h0000, rdata}, {16'h0000, expected}); // Valid with ack
            end
            req = 1'b0;
            wait_ack(1'b0, edges);
            if (!aborted) check_value("ack fall edges", 32'(edges), 32'(DROP_EDGES));
        end
        we    = 1'b0; // Bus back to idle
        dsn   = 2'b11;
        wdata = 16'h0000;
    endtask

    initial begin
        string       line;
        int          fd;
        int          n;
        int          gap;
        logic [7:0]  op;
        logic [23:0] f_addr;
        logic [7:0]  f_dsn;
        logic [15:0] f_wdata;
        logic [15:0] f_exp;

        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        dsn         = 2'b11;
        wdata       = 16'h0000;
        mismatches  = 0;
        timeouts    = 0;
        file_errors = 0;
        num_txn     = 0;
        line_no     = 0;
        aborted     = 1'b0;
        lfsr        = 32'hfc72;

        repeat (8) @(negedge clk); // Reset for 8 cycles
        rst = 1'b0;
        @(negedge clk);

        fd = $fopen("s16b_golden.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("Could not open the golden file s16b_golden.txt");
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                line_no++;
                n = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_dsn, f_wdata, f_exp);
                if (n < 1 || op == "#" || op == 8'h0a || op == 8'h0d) begin
                    continue; // Comment or blank
                end
                if (n != 5 || (op != "W" && op != "R")) begin
                    file_errors++;
                    $display("Golden file line %0d could not be parsed", line_no);
                end else begin
                    bus_transfer(op == "W", f_addr, f_dsn[1:0], f_wdata, f_exp);
                    num_txn++;
                    random_bits(3, gap); // Idle gap of 0 to 7 cycles
                    repeat (gap) @(negedge clk);
                end
            end
            $fclose(fd);
            if (num_txn == 0) begin
                file_errors++;
                $display("No transactions were found in the golden file");
            end
        end

        $display("Summary: %0d transactions, %0d mismatches, %0d timeouts, %0d file errors",
                 num_txn, mismatches, timeouts, file_errors);
        if (mismatches == 0 && timeouts == 0 && file_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: s16b_top.sv
// Memory mapper top level with bus controller, decoder, work RAM and video RAM
`timescale 1ns/1ps

module s16b_top #(
    parameter int WRAM_AW = 13, // 8 k words of work RAM
    parameter int VRAM_AW = 11  // 2 k words per video bank
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    we,
    input  s16b_bus_pkg::cpu_addr_t addr,
    input  s16b_bus_pkg::cpu_strb_t dsn,
    input  s16b_bus_pkg::cpu_data_t wdata,
    output logic                    ack,
    output s16b_bus_pkg::cpu_data_t rdata
);
    import s16b_bus_pkg::*;
    import s16b_map_pkg::*;

    cpu_addr_t    map_addr;
    cpu_data_t    map_data;
    cpu_strb_t    map_dsn;
    region_mask_t active;
    cpu_addr_t    ram_addr;
    cpu_data_t    ram_wdata;
    logic [1:0]   wram_be;
    cpu_data_t    wram_rdata;
    logic [1:0]   vram_be;
    logic [1:0]   vram_bank;
    cpu_data_t    vram_rdata;

    s16b_bus_ctrl u_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .dsn        (dsn),
        .wdata      (wdata),
        .ack        (ack),
        .rdata      (rdata),
        .map_addr   (map_addr),
        .map_data   (map_data),
        .map_dsn    (map_dsn),
        .active     (active),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .wram_be    (wram_be),
        .wram_rdata (wram_rdata),
        .vram_be    (vram_be),
        .vram_bank  (vram_bank),
        .vram_rdata (vram_rdata)
    );

    s16b_mem_map u_mem_map (
        .clk      (clk),
        .rst      (rst),
        .addr     (map_addr),
        .cpu_dout (map_data),
        .dswn     (map_dsn),
        .active   (active)
    );

    // Low word address bits only, RAM mirrors above them
    s16b_work_ram #(.WRAM_AW(WRAM_AW)) u_work_ram (
        .clk   (clk),
        .addr  (ram_addr[WRAM_AW:1]),
        .wdata (ram_wdata),
        .be    (wram_be),
        .rdata (wram_rdata)
    );

    s16b_video_ram #(.VRAM_AW(VRAM_AW)) u_video_ram (
        .clk   (clk),
        .bank  (vram_bank),
        .addr  (ram_addr[VRAM_AW:1]),
        .wdata (ram_wdata),
        .be    (vram_be),
        .rdata (vram_rdata)
    );

endmodule

// File: s16b_video_ram.sv
// Text, object and palette RAM banks for regions 4 to 6 with a shared bus port
`timescale 1ns/1ps

module s16b_video_ram #(
    parameter int VRAM_AW = 11 // Word address bits per bank
) (
    input  logic                    clk,
    input  logic [1:0]              bank,  // 0 text, 1 object, 2 palette
    input  logic [VRAM_AW-1:0]      addr,
    input  s16b_bus_pkg::cpu_data_t wdata,
    input  logic [1:0]              be,
    output s16b_bus_pkg::cpu_data_t rdata
);
    import s16b_bus_pkg::*;

    localparam int DEPTH = 2 ** VRAM_AW;

    logic [1:0] bank_q; // Bank of the word now in the read registers

    for (genvar b = 0; b < 3; b++) begin : g_bank
        cpu_data_t mem [DEPTH];
        cpu_data_t word_q;
        logic      bank_en;

        assign bank_en = (bank == 2'(b));

        always_ff @(posedge clk) begin
            if (bank_en && be[1]) mem[addr][15:8] <= wdata[15:8];
            if (bank_en && be[0]) mem[addr][7:0] <= wdata[7:0];
            word_q <= mem[addr]; // Every bank reads, mux picks later
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= bank;
    end

    // Output follows the bank that was addressed
    always_comb begin
        case (bank_q)
            2'd0:    rdata = g_bank[0].word_q;
            2'd1:    rdata = g_bank[1].word_q;
            2'd2:    rdata = g_bank[2].word_q;
            default: rdata = OPEN_BUS; // No fourth bank
        endcase
    end

endmodule

// File: s16b_work_ram.sv
// Region 3 work RAM, word wide with separate byte lanes and registered read
`timescale 1ns/1ps

module s16b_work_ram #(
    parameter int WRAM_AW = 13 // Word address bits
) (
    input  logic                    clk,
    input  logic [WRAM_AW-1:0]      addr,
    input  s16b_bus_pkg::cpu_data_t wdata,
    input  logic [1:0]              be,    // Bit 1 upper lane, bit 0 lower
    output s16b_bus_pkg::cpu_data_t rdata
);
    import s16b_bus_pkg::*;

    localparam int DEPTH = 2 ** WRAM_AW;

    // Upper address bits are not decoded, so the RAM mirrors
    // through the whole region
    cpu_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (be[1]) begin
            mem[addr][15:8] <= wdata[15:8]; // UDS lane
        end
        if (be[0]) begin
            mem[addr][7:0] <= wdata[7:0];   // LDS lane
        end
        rdata <= mem[addr]; // Old word on a write cycle
    end

endmodule

// File: s16b_bus_ctrl.sv
// Four-phase req/ack bus slave that sequences each access and routes it to a region target
`timescale 1ns/1ps

module s16b_bus_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  logic                       we,
    input  s16b_bus_pkg::cpu_addr_t    addr,
    input  s16b_bus_pkg::cpu_strb_t    dsn,
    input  s16b_bus_pkg::cpu_data_t    wdata,
    output logic                       ack,
    output s16b_bus_pkg::cpu_data_t    rdata,
    output s16b_bus_pkg::cpu_addr_t    map_addr,
    output s16b_bus_pkg::cpu_data_t    map_data,
    output s16b_bus_pkg::cpu_strb_t    map_dsn,
    input  s16b_map_pkg::region_mask_t active,
    output s16b_bus_pkg::cpu_addr_t    ram_addr,
    output s16b_bus_pkg::cpu_data_t    ram_wdata,
    output logic [1:0]                 wram_be,
    input  s16b_bus_pkg::cpu_data_t    wram_rdata,
    output logic [1:0]                 vram_be,
    output logic [1:0]                 vram_bank,
    input  s16b_bus_pkg::cpu_data_t    vram_rdata
);
    import s16b_bus_pkg::*;
    import s16b_map_pkg::*;

    bus_state_t state;
    cpu_addr_t  addr_q;    // Latched request
    cpu_data_t  wdata_q;
    cpu_strb_t  dsn_q;
    logic       we_q;
    logic [2:0] sel;       // Lowest active region
    logic       hit;       // Some region matched
    logic       wram_sel;
    logic       vram_sel;
    logic [2:0] vram_off;  // Region number relative to text RAM
    logic       wr_cycle;  // Write strobe window
    logic       wram_q;    // Target seen during ST_ACCESS
    logic       vram_q;

    // Request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            dsn_q   <= dsn;
            we_q    <= we;
        end
        if (state == ST_ACCESS) begin
            wram_q <= wram_sel; // Keeps read steering even if a config write moved the map
            vram_q <= vram_sel;
        end
        if (state == ST_DATA) begin
            if (wram_q) rdata <= wram_rdata;
            else if (vram_q) rdata <= vram_rdata;
            else rdata <= OPEN_BUS; // ROM, I/O or unmapped
        end
    end

    // Priority encode, region 0 wins
    always_comb begin
        sel = 3'd0;
        hit = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (active[i]) begin
                sel = 3'(i);
                hit = 1'b1;
            end
        end
    end

    assign wram_sel = hit && (sel == REGION_WRAM);
    assign vram_sel = hit && (sel >= REGION_TEXT) && (sel <= REGION_PAL);
    assign vram_off = sel - REGION_TEXT;
    assign wr_cycle = (state == ST_ACCESS) && we_q;

    assign map_addr  = addr_q;
    assign map_data  = wdata_q;
    assign map_dsn   = wr_cycle ? dsn_q : STRB_NONE; // Mapper only sees write strobes
    assign ram_addr  = addr_q;
    assign ram_wdata = wdata_q;
    assign wram_be   = (wr_cycle && wram_sel) ? ~dsn_q : 2'b00; // Active-high lanes
    assign vram_be   = (wr_cycle && vram_sel) ? ~dsn_q : 2'b00;
    assign vram_bank = vram_sel ? vram_off[1:0] : 2'd0; // Text 0, object 1, palette 2

    // Handshake sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) state <= ST_ACCESS;
                end
                ST_ACCESS: state <= ST_DATA; // RAM and mapper act on this edge
                ST_DATA:   state <= ST_ACK;  // rdata settles here
                ST_ACK: begin
                    if (!req) begin
                        state <= ST_IDLE;
                        ack   <= 1'b0;       // Falls on first req-low edge
                    end else begin
                        ack   <= 1'b1;       // Held while master waits
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: s16b_mem_map.sv
// Eight-region address decoder with CPU-programmable base pages and size codes
`timescale 1ns/1ps

module s16b_mem_map (
    input  logic                       clk,
    input  logic                       rst,
    input  s16b_bus_pkg::cpu_addr_t    addr,
    input  s16b_bus_pkg::cpu_data_t    cpu_dout,
    input  s16b_bus_pkg::cpu_strb_t    dswn,
    output s16b_map_pkg::region_mask_t active
);
    import s16b_map_pkg::*;

    region_base_t base [8]; // Page of each region
    region_size_t size [8]; // Size code of each region
    logic         none;     // No region claims the address
    logic         cfg_wr;   // Write to the mapper itself

    // Base bits that take part in the compare
    function automatic region_base_t care_mask(input region_size_t code);
        region_base_t m;
        case (code)
            SIZE_64K:  m = 8'hff;
            SIZE_128K: m = 8'hfe;
            SIZE_512K: m = 8'hf8;
            default:   m = 8'he0; // 2 MB
        endcase
        return m;
    endfunction

    // Zero-cycle decode
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            // Match when every cared-for bit agrees
            active[r] = ((addr[23:16] ^ base[r]) & care_mask(size[r])) == 8'h00;
        end
    end

    assign none   = (active == '0);
    assign cfg_wr = none && !dswn[0]; // Needs LDS, upper lane alone does nothing

    // A4..A2 pick the region, A1 picks base or size
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < 8; r++) begin
                base[r] <= '0; // Every region on page 0 out of reset
                size[r] <= SIZE_64K;
            end
        end else if (cfg_wr) begin
            if (addr[1]) begin
                base[addr[4:2]] <= cpu_dout[7:0];
            end else begin
                size[addr[4:2]] <= cpu_dout[1:0]; // Upper bits of D7..D2 dropped
            end
        end
    end

endmodule

// File: s16b_map_pkg.sv
// Region numbering, size codes and bus sequencer states for the memory mapper
package s16b_map_pkg;

    // One match flag per region, bit n for region n
    typedef logic [7:0] region_mask_t;

    // Base page, compared with A23..A16
    typedef logic [7:0] region_base_t;

    // Size code of a region
    typedef logic [1:0] region_size_t;

    localparam region_size_t SIZE_64K  = 2'd0; // All 8 base bits compared
    localparam region_size_t SIZE_128K = 2'd1; // Base bit 0 ignored
    localparam region_size_t SIZE_512K = 2'd2; // Base bits 2..0 ignored
    localparam region_size_t SIZE_2M   = 2'd3; // Base bits 4..0 ignored

    // Regions with a target on this board
    localparam logic [2:0] REGION_WRAM = 3'd3; // 68000 work RAM
    localparam logic [2:0] REGION_TEXT = 3'd4; // Text layer RAM
    localparam logic [2:0] REGION_OBJ  = 3'd5; // Object RAM
    localparam logic [2:0] REGION_PAL  = 3'd6; // Palette RAM

    // Bus controller sequence, one transaction at a time
    typedef enum logic [1:0] {
        ST_IDLE,   // Waiting for req
        ST_ACCESS, // Mapper and RAM operation
        ST_DATA,   // Read data capture
        ST_ACK     // ack high until req drops
    } bus_state_t;

endpackage

// File: s16b_bus_pkg.sv
// CPU bus types for the 68000-style board and the open-bus read value
package s16b_bus_pkg;

    // 68000 word address, byte bit A0 is not on the bus
    typedef logic [23:1] cpu_addr_t;

    // Data bus, upper lane on D15..D8
    typedef logic [15:0] cpu_data_t;

    // Active-low data strobes
    // Bit 1 is UDS (D15..D8), bit 0 is LDS (D7..D0)
    typedef logic [1:0]  cpu_strb_t;

    // Value seen on reads with no target behind the region
    localparam cpu_data_t OPEN_BUS = 16'hffff;

    // Idle strobe pattern, both lanes released
    localparam cpu_strb_t STRB_NONE = 2'b11;

endpackage
